// ==== uartTop.f ====
design/uartPkg.sv
design/uartBaudGen.sv
design/uartTxFifo.sv
design/uartTrans.sv
design/uartRecv.sv
design/uartApbRegs.sv
design/uartTop.sv
dv/uartTop_chk.sv
dv/uartTb.sv

// ==== Bender.yml ====
package:
  name: uartTop

sources:
  - design/uartPkg.sv
  - design/uartBaudGen.sv
  - design/uartTxFifo.sv
  - design/uartTrans.sv
  - design/uartRecv.sv
  - design/uartApbRegs.sv
  - design/uartTop.sv
  - target: simulation
    files:
      - dv/uartTop_chk.sv
      - dv/uartTb.sv

// ==== dv/uartTb.sv ====
//////////////////////////////
// uart peripheral testbench
// clock, reset, apb tasks, tx to rx loopback
// reference model, compare process, watchdog
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTb;

	localparam int clkPeriod = 10;
	localparam int maxDiv    = 7;	// slowest rate used below
	localparam int numFrames = 30;	// frames sent over all tests plus one
	localparam int watchdogNs = numFrames * 10 * uartPkg::overSample * (maxDiv + 1)
		* clkPeriod * 2;	// twice the serial time

	logic             clk;
	logic             reset;
	uartPkg::apbReq_t apbReq;
	uartPkg::apbRsp_t apbRsp;
	logic             txLine;
	logic             rxLine;
	logic             rxDrive;	// direct rx drive for bad frames
	logic             useDirect;
	logic [31:0]      lfsrState;
	int               curDiv;	// divisor the dut runs at
	int               errCount;
	int               checkCount;

	// pending comparisons drained on each rising edge
	string       nameQ [$];
	logic [31:0] expQ  [$];
	logic [31:0] actQ  [$];

	assign rxLine = useDirect ? rxDrive : txLine;	// loopback unless injecting

	uartTop i_uartTop (
		.clk    (clk),
		.reset  (reset),
		.apbReq (apbReq),
		.apbRsp (apbRsp),
		.tx     (txLine),
		.rx     (rxLine)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// line levels of one 8N1 frame with index 0 sent first
	function automatic logic [9:0] frameLevels(input logic [7:0] b);
		logic [9:0] f;
		f[0] = 1'b0;	// start
		for (int i = 0; i < uartPkg::dataBits; i++)
			f[i + 1] = b[i];	// lsb first
		f[9] = 1'b1;	// stop
		return f;
	endfunction

	// bytes left waiting in the fifo after a burst of writes
	function automatic int queuedAfterBurst(input int nWritten);
		int q;
		q = nWritten - 1;	// first byte is popped at once
		if (q > uartPkg::fifoDepth)
			q = uartPkg::fifoDepth;	// the rest is dropped
		if (q < 0)
			q = 0;
		return q;
	endfunction

	function automatic uartPkg::uartStatus_t statusWord(input logic full, input logic empty,
		input logic busy, input logic valid, input logic overrun, input logic ferr);
		uartPkg::uartStatus_t s;
		s           = '0;
		s.txFull    = full;
		s.txEmpty   = empty;
		s.txBusy    = busy;
		s.rxValid   = valid;
		s.rxOverrun = overrun;
		s.frameErr  = ferr;
		return s;
	endfunction

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		else
			return s >> 1;
	endfunction

	task automatic randByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrNext(lfsrState);	// one step per bit
			b[i]      = lfsrState[0];
		end
	endtask

	//////////////////////////////
	// compare process
	//////////////////////////////
	task automatic queueCheck(input string name, input logic [31:0] exp, input logic [31:0] act);
		nameQ.push_back(name);
		expQ.push_back(exp);
		actQ.push_back(act);
	endtask

	always @(posedge clk)
	begin : compareLoop
		string       nm;
		logic [31:0] e;
		logic [31:0] a;
		while (expQ.size() > 0)
		begin
			nm = nameQ.pop_front();
			e  = expQ.pop_front();
			a  = actQ.pop_front();
			checkCount++;
			assert (a === e)
			else
			begin
				errCount++;
				$display("ERROR %s expected %h actual %h", nm, e, a);
			end
		end
	end

	//////////////////////////////
	// apb access driven on falling edges
	//////////////////////////////
	task automatic apbWrite(input logic [uartPkg::regAddrLen-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		apbReq.psel    = 1'b1;	// setup
		apbReq.penable = 1'b0;
		apbReq.pwrite  = 1'b1;
		apbReq.paddr   = addr;
		apbReq.pwdata  = data;
		@(negedge clk);
		apbReq.penable = 1'b1;	// access
		#2;
		queueCheck("pslverr", 32'd0, apbRsp.pslverr);
		queueCheck("pready", 32'd1, apbRsp.pready);
		@(negedge clk);
		apbReq.psel    = 1'b0;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = 1'b0;
	endtask

	task automatic apbRead(input logic [uartPkg::regAddrLen-1:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge clk);
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = 1'b0;
		apbReq.paddr   = addr;
		apbReq.pwdata  = '0;
		@(negedge clk);
		apbReq.penable = 1'b1;
		#2;	// prdata settled within the access cycle
		data = apbRsp.prdata;
		err  = apbRsp.pslverr;
		queueCheck("pready", 32'd1, apbRsp.pready);
		@(negedge clk);
		apbReq.psel    = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	// poll status until the transmitter has drained
	task automatic waitTxIdle();
		logic [31:0]          d;
		logic                 e;
		uartPkg::uartStatus_t st;
		int                   polls;
		int                   limit;
		limit = (uartPkg::fifoDepth + 2) * 10 * uartPkg::overSample * (curDiv + 1);
		polls = 0;
		st    = '0;
		while (!(st.txEmpty && !st.txBusy) && polls < limit)
		begin
			apbRead(uartPkg::addrStatus, d, e);
			st = uartPkg::uartStatus_t'(d[7:0]);
			polls++;
		end
		assert (st.txEmpty && !st.txBusy)
		else
		begin
			errCount++;
			$display("transmitter still busy after %0d status polls", limit);
		end
	endtask

	// wait for rxValid then read the byte and see the holding register empty
	task automatic receiveByte(output logic [7:0] b);
		logic [31:0]          d;
		logic                 e;
		uartPkg::uartStatus_t st;
		int                   polls;
		int                   limit;
		limit = 2 * 10 * uartPkg::overSample * (curDiv + 1);
		polls = 0;
		st    = '0;
		while (!st.rxValid && polls < limit)
		begin
			apbRead(uartPkg::addrStatus, d, e);
			st = uartPkg::uartStatus_t'(d[7:0]);
			polls++;
		end
		assert (st.rxValid)
		else
		begin
			errCount++;
			$display("no byte arrived on rx within %0d status polls", limit);
		end
		apbRead(uartPkg::addrData, d, e);
		b = d[7:0];
		apbRead(uartPkg::addrStatus, d, e);
		st = uartPkg::uartStatus_t'(d[7:0]);
		queueCheck("rxValid", 32'd0, st.rxValid);
	endtask

	task automatic setDivisor(input int value);
		logic [31:0] d;
		logic        e;
		waitTxIdle();
		apbWrite(uartPkg::addrDiv, value);
		curDiv = value;
		apbRead(uartPkg::addrDiv, d, e);
		queueCheck("divisor", value, d);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic resetValues();
		logic [31:0] d;
		logic        e;
		apbRead(uartPkg::addrStatus, d, e);
		queueCheck("status", statusWord(0, 1, 0, 0, 0, 0), d[7:0]);	// txEmpty only
		queueCheck("pslverr", 32'd0, e);
		apbRead(uartPkg::addrDiv, d, e);
		queueCheck("divisor", uartPkg::divReset, d);
		queueCheck("tx", 32'd1, txLine);
		apbRead(4'hc, d, e);	// unmapped
		queueCheck("pslverr", 32'd1, e);
	endtask

	// sample one frame mid-bit straight off the tx pin
	task automatic frameShape();
		logic [7:0] b;
		logic [7:0] got;
		logic [9:0] seen;
		int         bitClocks;
		int         n;
		bitClocks = uartPkg::overSample * (curDiv + 1);
		randByte(b);
		apbWrite(uartPkg::addrData, b);
		n = 0;
		while (txLine !== 1'b0 && n < 4 * bitClocks)
		begin
			@(negedge clk);
			n++;
		end
		assert (txLine === 1'b0)
		else
		begin
			errCount++;
			$display("tx never dropped to a start bit");
		end
		repeat (bitClocks / 2) @(negedge clk);	// middle of start bit
		for (int i = 0; i < 10; i++)
		begin
			seen[i] = txLine;
			if (i < 9)
				repeat (bitClocks) @(negedge clk);
		end
		queueCheck("tx frame", frameLevels(b), seen);
		receiveByte(got);	// looped back as well
		queueCheck("rx data", b, got);
	endtask

	// burst of writes then every accepted byte back in order
	task automatic loopbackRun(input int n);
		logic [7:0]  sent [$];
		logic [7:0]  b;
		logic [31:0] d;
		logic        e;
		int          queued;
		queued = queuedAfterBurst(n);
		for (int i = 0; i < n; i++)
		begin
			randByte(b);
			sent.push_back(b);
			apbWrite(uartPkg::addrData, b);
		end
		apbRead(uartPkg::addrStatus, d, e);	// first frame still going out
		queueCheck("status", statusWord(queued == uartPkg::fifoDepth, queued == 0, 1, 0, 0, 0),
			d[7:0]);
		for (int i = 0; i < queued + 1; i++)
		begin
			receiveByte(b);
			queueCheck("rx data", sent[i], b);
		end
		waitTxIdle();
		apbRead(uartPkg::addrStatus, d, e);	// dropped bytes never show up
		queueCheck("status", statusWord(0, 1, 0, 0, 0, 0), d[7:0]);
	endtask

	task automatic overrunRun();
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [31:0] d;
		logic        e;
		randByte(b0);
		randByte(b1);
		apbWrite(uartPkg::addrData, b0);
		apbWrite(uartPkg::addrData, b1);
		waitTxIdle();	// both rx events are in by now
		apbRead(uartPkg::addrStatus, d, e);
		queueCheck("status", statusWord(0, 1, 0, 1, 1, 0), d[7:0]);
		apbRead(uartPkg::addrData, d, e);
		queueCheck("rx data", b1, d[7:0]);	// newest byte kept
		apbWrite(uartPkg::addrStatus, 32'hff);
		apbRead(uartPkg::addrStatus, d, e);
		queueCheck("status", statusWord(0, 1, 0, 0, 0, 0), d[7:0]);
	endtask

	// frame with a low stop bit driven straight onto rx
	task automatic badStopBit();
		logic [7:0]  b;
		logic [9:0]  frame;
		logic [31:0] d;
		logic        e;
		int          bitClocks;
		bitClocks = uartPkg::overSample * (curDiv + 1);
		randByte(b);
		frame    = frameLevels(b);
		frame[9] = 1'b0;
		@(negedge clk);
		useDirect = 1'b1;
		for (int i = 0; i < 10; i++)
		begin
			rxDrive = frame[i];
			repeat (bitClocks) @(negedge clk);
		end
		rxDrive = 1'b1;
		repeat (2 * bitClocks) @(negedge clk);
		useDirect = 1'b0;	// back to loopback with the line idle high
		apbRead(uartPkg::addrStatus, d, e);
		queueCheck("status", statusWord(0, 1, 0, 1, 0, 1), d[7:0]);
		apbRead(uartPkg::addrData, d, e);
		queueCheck("rx data", b, d[7:0]);
		apbWrite(uartPkg::addrStatus, 32'hff);
		apbRead(uartPkg::addrStatus, d, e);
		queueCheck("status", statusWord(0, 1, 0, 0, 0, 0), d[7:0]);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		reset      = 1'b1;
		apbReq     = '0;
		rxDrive    = 1'b1;
		useDirect  = 1'b0;
		lfsrState  = 32'hb1ceb3ed;
		curDiv     = uartPkg::divReset;
		errCount   = 0;
		checkCount = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		resetValues();
		frameShape();
		loopbackRun(4);
		setDivisor(7);
		loopbackRun(4);
		setDivisor(3);
		loopbackRun(18);	// overflows the fifo
		overrunRun();
		badStopBit();

		@(posedge clk);	// drain the compare queue
		@(negedge clk);
		errCount += i_uartTop.i_uartTopChk.failCount;
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(watchdogNs);
		$display("watchdog expired after %0d ns, tests did not finish", watchdogNs);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/uartTop_chk.sv ====
//////////////////////////////
// apb and serial line assertions
// bound into the uart top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTopChk (
	input logic             clk,
	input logic             reset,
	input uartPkg::apbReq_t apbReq,
	input uartPkg::apbRsp_t apbRsp,
	input logic             tx,
	input logic             sTick,
	input logic             txStart,
	input logic             txDoneTick,
	input logic             txBusy
);

	int failCount = 0;	// assertions that fired

	// every setup is followed by an access that completes at once
	readyHigh: assert property (@(posedge clk) disable iff (reset)
		(apbReq.psel && !apbReq.penable) |=> (apbReq.penable && apbRsp.pready))
		else
		begin
			failCount++;
			$error("access after setup missing or pready low");
		end

	// a pop in idle puts the start bit on tx two cycles later
	popStartsFrame: assert property (@(posedge clk) disable iff (reset)
		txDoneTick |-> (txStart && !txBusy) ##1 txBusy ##1 !tx)
		else
		begin
			failCount++;
			$error("txDoneTick did not start a frame");
		end

	idleHigh: assert property (@(posedge clk) disable iff (reset) !txBusy |-> tx)
		else
		begin
			failCount++;
			$error("tx low while transmitter idle");
		end

	tickWidth: assert property (@(posedge clk) disable iff (reset) sTick |=> !sTick)
		else
		begin
			failCount++;
			$error("sTick wider than one cycle");
		end

	// error only in the access cycle right after its setup
	errInAccess: assert property (@(posedge clk) disable iff (reset)
		apbRsp.pslverr |-> (apbReq.psel && apbReq.penable
			&& $past(apbReq.psel && !apbReq.penable)))
		else
		begin
			failCount++;
			$error("pslverr outside an access cycle");
		end

endmodule

bind uartTop uartTopChk i_uartTopChk (
	.clk        (clk),
	.reset      (reset),
	.apbReq     (apbReq),
	.apbRsp     (apbRsp),
	.tx         (tx),
	.sTick      (sTick),
	.txStart    (txStart),
	.txDoneTick (txDoneTick),
	.txBusy     (txBusy)
);

`default_nettype wire

// ==== design/uartTop.sv ====
//////////////////////////////
// uart peripheral top level
// apb regs, baud gen, tx fifo
// transmitter and receiver
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTop (
	input  logic             clk,
	input  logic             reset,
	input  uartPkg::apbReq_t apbReq,
	output uartPkg::apbRsp_t apbRsp,
	output logic             tx,
	input  logic             rx
);

	logic                         fifoPush;
	logic [uartPkg::dataBits-1:0] fifoData;
	logic [uartPkg::dataBits-1:0] fifoHead;	// popped byte into the transmitter
	logic                         fifoEmpty;
	logic                         fifoFull;
	logic                         txStart;
	logic                         txDoneTick;	// fifo pop
	logic                         txBusy;
	logic                         sTick;
	logic [uartPkg::divLen-1:0]   divisor;
	logic                         divLoad;
	uartPkg::rxEvent_t            rxEvent;

	assign txStart = !fifoEmpty;

	uartApbRegs i_uartApbRegs (
		.clk       (clk),
		.reset     (reset),
		.apbReq    (apbReq),
		.apbRsp    (apbRsp),
		.fifoPush  (fifoPush),
		.fifoData  (fifoData),
		.fifoEmpty (fifoEmpty),
		.fifoFull  (fifoFull),
		.txBusy    (txBusy),
		.rxEvent   (rxEvent),
		.divisor   (divisor),
		.divLoad   (divLoad)
	);

	uartBaudGen i_uartBaudGen (
		.clk     (clk),
		.reset   (reset),
		.divisor (divisor),
		.divLoad (divLoad),
		.sTick   (sTick)
	);

	uartTxFifo i_uartTxFifo (
		.clk    (clk),
		.reset  (reset),
		.push   (fifoPush),
		.wrData (fifoData),
		.pop    (txDoneTick),
		.rdData (fifoHead),
		.empty  (fifoEmpty),
		.full   (fifoFull)
	);

	uartTrans i_uartTrans (
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.txStart    (txStart),
		.din        (fifoHead),
		.tx         (tx),
		.txDoneTick (txDoneTick),
		.busy       (txBusy)
	);

	uartRecv i_uartRecv (
		.clk     (clk),
		.reset   (reset),
		.sTick   (sTick),
		.rx      (rx),
		.rxEvent (rxEvent)
	);

endmodule

`default_nettype wire

// ==== design/uartApbRegs.sv ====
//////////////////////////////
// apb slave register block
// data, status and divisor registers
// rx holding byte and sticky errors
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartApbRegs (
	input  logic                         clk,
	input  logic                         reset,
	input  uartPkg::apbReq_t             apbReq,
	output uartPkg::apbRsp_t             apbRsp,
	output logic                         fifoPush,
	output logic [uartPkg::dataBits-1:0] fifoData,
	input  logic                         fifoEmpty,
	input  logic                         fifoFull,
	input  logic                         txBusy,
	input  uartPkg::rxEvent_t            rxEvent,
	output logic [uartPkg::divLen-1:0]   divisor,
	output logic                         divLoad
);

	uartPkg::uartStatus_t         status;
	uartPkg::uartStatus_t         clrMask;	// write-one-to-clear view of pwdata
	logic                         access, wrEn, rdEn;
	logic                         hitData, hitStatus, hitDiv;
	logic                         dataRead;
	logic [uartPkg::dataBits-1:0] rxData;
	logic                         rxValid, rxOverrun, frameErr;
	logic [31:0]                  prdata;

	//////////////////////////////
	// address and phase decode
	//////////////////////////////
	assign access    = apbReq.psel && apbReq.penable;	// access phase
	assign wrEn      = access && apbReq.pwrite;
	assign rdEn      = access && !apbReq.pwrite;
	assign hitData   = (apbReq.paddr == uartPkg::addrData);
	assign hitStatus = (apbReq.paddr == uartPkg::addrStatus);
	assign hitDiv    = (apbReq.paddr == uartPkg::addrDiv);
	assign dataRead  = rdEn && hitData;
	assign clrMask   = uartPkg::uartStatus_t'(apbReq.pwdata[7:0]);

	// fifo drops the byte itself when full
	assign fifoPush = wrEn && hitData;
	assign fifoData = apbReq.pwdata[uartPkg::dataBits-1:0];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divisor <= uartPkg::divReset;
			divLoad <= 1'b0;
		end
		else
		begin
			if (wrEn && hitDiv)
				divisor <= apbReq.pwdata[uartPkg::divLen-1:0];
			divLoad <= wrEn && hitDiv;	// baud gen restarts once divisor is in
		end
	end

	// holding byte, newest frame wins
	always_ff @(posedge clk)
	begin
		if (rxEvent.valid)
			rxData <= rxEvent.data;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxValid   <= 1'b0;
			rxOverrun <= 1'b0;
			frameErr  <= 1'b0;
		end
		else
		begin
			if (rxEvent.valid)
				rxValid <= 1'b1;
			else if (dataRead)
				rxValid <= 1'b0;

			// unread byte overwritten, set beats clear
			if (rxEvent.valid && rxValid && !dataRead)
				rxOverrun <= 1'b1;
			else if (wrEn && hitStatus && clrMask.rxOverrun)
				rxOverrun <= 1'b0;

			if (rxEvent.valid && rxEvent.frameErr)
				frameErr <= 1'b1;
			else if (wrEn && hitStatus && clrMask.frameErr)
				frameErr <= 1'b0;
		end
	end

	//////////////////////////////
	// status word and read mux
	//////////////////////////////
	always_comb
	begin
		status           = '0;
		status.txFull    = fifoFull;
		status.txEmpty   = fifoEmpty;
		status.txBusy    = txBusy;
		status.rxValid   = rxValid;
		status.rxOverrun = rxOverrun;
		status.frameErr  = frameErr;
	end

	always_comb
	begin
		prdata = '0;
		case (apbReq.paddr)
			uartPkg::addrData:   prdata[uartPkg::dataBits-1:0] = rxData;
			uartPkg::addrStatus: prdata[7:0] = status;
			uartPkg::addrDiv:    prdata[uartPkg::divLen-1:0] = divisor;
			default:             prdata = '0;	// unmapped
		endcase
	end

	assign apbRsp.prdata  = prdata;
	assign apbRsp.pready  = 1'b1;	// no wait states
	assign apbRsp.pslverr = access && !(hitData || hitStatus || hitDiv);

endmodule

`default_nettype wire

// ==== design/uartRecv.sv ====
//////////////////////////////
// serial receiver, 16x oversampling
// rx synchronizer, mid-bit sampling
// framing error on a low stop bit
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRecv (
	input  logic              clk,
	input  logic              reset,
	input  logic              sTick,
	input  logic              rx,
	output uartPkg::rxEvent_t rxEvent
);

	logic                                   rxMeta, rxSync, rxPrev;
	logic                                   rxFall;	// start of a start bit
	uartPkg::serState_t                     stateReg, stateNext;
	logic [$clog2(uartPkg::overSample)-1:0] sReg, sNext;
	logic [$clog2(uartPkg::dataBits)-1:0]   nReg, nNext;
	logic [uartPkg::dataBits-1:0]           bReg, bNext;
	logic                                   evValid, validNext;
	logic                                   evErr, errNext;

	// two flop sync plus one for edge detect, idle high
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign rxFall = rxPrev && !rxSync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::serIdle;
			sReg     <= '0;
			nReg     <= '0;
			evValid  <= 1'b0;
			evErr    <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			evValid  <= validNext;
			evErr    <= errNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;	// received byte, no reset
	end

	//////////////////////////////
	// receive fsm
	//////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		validNext = 1'b0;
		errNext   = evErr;

		case (stateReg)
			uartPkg::serIdle:
				if (rxFall)
				begin
					stateNext = uartPkg::serStart;
					sNext     = '0;
				end

			uartPkg::serStart:
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample / 2 - 1))	// middle of start bit
					begin
						sNext     = '0;
						nNext     = '0;
						// glitch if the line is back high
						stateNext = rxSync ? uartPkg::serIdle : uartPkg::serData;
					end
					else
						sNext = sReg + 1'b1;
				end

			uartPkg::serData:
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartPkg::dataBits-1:1]};	// lsb arrives first
						if (nReg == (uartPkg::dataBits - 1))
							stateNext = uartPkg::serStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end

			uartPkg::serStop:
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample - 1))	// mid stop bit
					begin
						validNext = 1'b1;
						errNext   = !rxSync;	// stop must be high
						stateNext = uartPkg::serIdle;
					end
					else
						sNext = sReg + 1'b1;
				end

			default: stateNext = uartPkg::serIdle;
		endcase
	end

	assign rxEvent.valid    = evValid;
	assign rxEvent.data     = bReg;
	assign rxEvent.frameErr = evErr;

endmodule

`default_nettype wire

// ==== design/uartTrans.sv ====
//////////////////////////////
// serial transmitter
// idle/start/data/stop fsm on 16x ticks
// lsb first 8N1, txDoneTick pops the fifo
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTrans (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         sTick,
	input  logic                         txStart,	// fifo not empty
	input  logic [uartPkg::dataBits-1:0] din,
	output logic                         tx,
	output logic                         txDoneTick,
	output logic                         busy
);

	uartPkg::serState_t                         stateReg, stateNext;
	logic [$clog2(uartPkg::overSample)-1:0]     sReg, sNext;	// tick count within a bit
	logic [$clog2(uartPkg::dataBits)-1:0]       nReg, nNext;	// data bit index
	logic [uartPkg::dataBits-1:0]               bReg, bNext;	// shift register
	logic                                       txReg, txNext;

	// control state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::serIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	// payload shifter
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			uartPkg::serIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// fifo pops this same cycle
					stateNext  = uartPkg::serStart;
					sNext      = '0;
				end
			end

			uartPkg::serStart:
			begin
				txNext = 1'b0;	// start bit
				bNext  = din;	// popped byte valid from here on
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample - 1))
					begin
						stateNext = uartPkg::serData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartPkg::serData:
			begin
				txNext = bReg[0];	// lsb first
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == (uartPkg::dataBits - 1))
							stateNext = uartPkg::serStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartPkg::serStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == (uartPkg::overSample - 1))
						stateNext = uartPkg::serIdle;	// one idle cycle before next frame
					else
						sNext = sReg + 1'b1;
				end
			end

			default: stateNext = uartPkg::serIdle;
		endcase
	end

	assign tx   = txReg;
	assign busy = (stateReg != uartPkg::serIdle);

endmodule

`default_nettype wire

// ==== design/uartTxFifo.sv ====
//////////////////////////////
// transmit fifo, 16 x 8 bit
// circular buffer with occupancy count
// rdData holds the byte last popped
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTxFifo (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push,
	input  logic [uartPkg::dataBits-1:0] wrData,
	input  logic                         pop,
	output logic [uartPkg::dataBits-1:0] rdData,
	output logic                         empty,
	output logic                         full
);

	logic [uartPkg::dataBits-1:0]    mem [uartPkg::fifoDepth];
	logic [uartPkg::fifoAddrLen-1:0] wrPtr;
	logic [uartPkg::fifoAddrLen-1:0] rdPtr;
	logic [uartPkg::fifoCntLen-1:0]  count;	// entries in use
	logic                            doPush;
	logic                            doPop;

	assign empty  = (count == '0);
	assign full   = (count == uartPkg::fifoCntLen'(uartPkg::fifoDepth));
	assign doPop  = pop && !empty;	// pop on empty ignored
	assign doPush = push && (!full || doPop);	// full but draining this cycle is ok

	// storage and popped word
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
		if (doPop)
			rdData <= mem[rdPtr];	// transmitter takes it next cycle
	end

	// pointers wrap naturally at fifoDepth
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;

			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/uartBaudGen.sv ====
//////////////////////////////
// programmable baud tick generator
// one clk wide oversampling tick
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartBaudGen (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [uartPkg::divLen-1:0] divisor,
	input  logic                       divLoad,	// divisor just rewritten
	output logic                       sTick
);

	logic [uartPkg::divLen-1:0] cnt;	// down-counter, tick at zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt   <= uartPkg::divReset;
			sTick <= 1'b0;
		end
		else if (divLoad)
		begin
			cnt   <= divisor;	// restart cleanly at the new rate
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt   <= divisor;
			sTick <= 1'b1;	// every divisor+1 clocks
		end
		else
		begin
			cnt   <= cnt - 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/uartPkg.sv ====
//////////////////////////////
// shared definitions for the uart peripheral
// frame constants, fifo sizes, baud divisor
// apb register map and bus structs
// status word, rx event, serial fsm states
//////////////////////////////

`default_nettype none

package uartPkg;

	// frame format, 8N1
	localparam int dataBits   = 8;
	localparam int overSample = 16;	// ticks per bit, stop bit too

	// transmit fifo
	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;
	localparam int fifoCntLen  = 5;	// holds 0..fifoDepth

	// baud divisor
	localparam int divLen = 16;
	localparam logic [divLen-1:0] divReset = 16'd3;	// one tick every 4 clocks

	// register map
	localparam int regAddrLen = 4;
	localparam logic [regAddrLen-1:0] addrData   = 4'h0;
	localparam logic [regAddrLen-1:0] addrStatus = 4'h4;
	localparam logic [regAddrLen-1:0] addrDiv    = 4'h8;

	// status word as seen over apb, msb first
	typedef struct packed {
		logic       txFull;
		logic       txEmpty;
		logic       txBusy;
		logic       rxValid;
		logic       rxOverrun;	// sticky
		logic       frameErr;	// sticky
		logic [1:0] reserved;	// read as zero
	} uartStatus_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [regAddrLen-1:0] paddr;
		logic [31:0]           pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRsp_t;

	// one received frame, valid for a single cycle
	typedef struct packed {
		logic                valid;
		logic [dataBits-1:0] data;
		logic                frameErr;
	} rxEvent_t;

	// shared by the transmit and receive fsms
	typedef enum logic [1:0] {
		serIdle  = 2'b00,
		serStart = 2'b01,
		serData  = 2'b10,
		serStop  = 2'b11
	} serState_t;

endpackage

`default_nettype wire
